//--- hw/soc_bus_pkg.sv
`default_nettype none

package soc_bus_pkg;

	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;
	localparam int SEL_W = DATA_W / 8;

	typedef logic [ADDR_W-1:0] addr_t;	// Byte address
	typedef logic [DATA_W-1:0] data_t;
	typedef logic [SEL_W-1:0] sel_t;	// One bit per byte lane

	// Master index
	typedef logic master_t;

	localparam int NUM_MASTERS = 2;
	localparam master_t MST_CPU = 1'b0;
	localparam master_t MST_GFX = 1'b1;

	typedef enum logic [1:0] {
		ARB_IDLE,
		ARB_ADDR,	// Slave strobe cycle
		ARB_WAIT
	} arb_state_t;

endpackage

`default_nettype wire

//--- hw/soc_map_pkg.sv
`default_nettype none

package soc_map_pkg;

	typedef enum logic [1:0] {
		REG_BOOT,
		REG_GFX,
		REG_NONE	// SDRAM window and all holes
	} region_t;

	// Bootloader RAM, 32 KiB
	localparam logic [31:0] BOOT_BASE = 32'h0201_0000;
	localparam int BOOT_ADDR_BITS = 15;

	// Graphics register block
	localparam logic [31:0] GFX_BASE = 32'h0200_0000;
	localparam int GFX_ADDR_BITS = 8;

	// Word offset inside the graphics window
	typedef logic [GFX_ADDR_BITS-3:0] gfx_ofs_t;

	localparam gfx_ofs_t GFX_CTRL = 'd0;		// Bit 0 display enable
	localparam gfx_ofs_t GFX_FB_BASE = 'd1;
	localparam gfx_ofs_t GFX_CURSOR = 'd2;
	localparam gfx_ofs_t GFX_ID = 'd3;		// Read only

	localparam logic [31:0] GFX_ID_VALUE = 32'h4758_0001;

endpackage

`default_nettype wire

//--- hw/reset_seq.sv
`timescale 1ns/1ps
`default_nettype none

module reset_seq #(
	parameter int RESET_CYCLES = 255
) (
	input wire hdmi_pixClk,
	input wire rst_n,
	output logic sys_rst_n
);

	localparam int CNT_W = $clog2(RESET_CYCLES + 2);

	logic rst_q;	// External reset, registered once
	logic [CNT_W-1:0] cnt;

	always_ff @(posedge hdmi_pixClk) begin
		if (!rst_n) begin
			rst_q <= 1'b0;
			cnt <= '0;
			sys_rst_n <= 1'b0;
		end else begin
			rst_q <= 1'b1;
			if (rst_q && cnt != CNT_W'(RESET_CYCLES))
				cnt <= cnt + 1'b1;
			sys_rst_n <= rst_q && (cnt == CNT_W'(RESET_CYCLES));
		end
	end

endmodule

`default_nettype wire

//--- hw/bus_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module bus_ctrl
	import soc_bus_pkg::*;
	import soc_map_pkg::*;
(
	input wire hdmi_pixClk,
	input wire sys_rst_n,

	input wire cpu_cyc,
	input wire cpu_stb,
	input wire cpu_we,
	input wire addr_t cpu_adr,
	input wire sel_t cpu_sel,
	input wire data_t cpu_wdata,
	output logic cpu_ack,
	output logic cpu_err,
	output data_t cpu_rdata,

	input wire gfx_cyc,
	input wire gfx_stb,
	input wire gfx_we,
	input wire addr_t gfx_adr,
	input wire sel_t gfx_sel,
	input wire data_t gfx_wdata,
	output logic gfx_ack,
	output logic gfx_err,
	output data_t gfx_rdata,

	output addr_t slv_adr,
	output logic slv_we,
	output sel_t slv_sel,
	output data_t slv_wdata,

	output logic boot_stb,
	input wire boot_ack,
	input wire data_t boot_rdata,

	output logic gfx_slv_stb,
	input wire gfx_slv_ack,
	input wire data_t gfx_slv_rdata
);

	arb_state_t state;
	master_t grant;		// Also the last served master
	master_t next_grant;
	region_t region;
	logic err_q;
	logic resp_ack;
	data_t resp_rdata;

	logic [NUM_MASTERS-1:0] req;
	logic m_cyc [NUM_MASTERS];
	addr_t m_adr [NUM_MASTERS];
	logic m_we [NUM_MASTERS];
	sel_t m_sel [NUM_MASTERS];
	data_t m_wdata [NUM_MASTERS];

	function automatic region_t decode(input addr_t a);
		if (a[31:BOOT_ADDR_BITS] == BOOT_BASE[31:BOOT_ADDR_BITS])
			return REG_BOOT;
		if (a[31:GFX_ADDR_BITS] == GFX_BASE[31:GFX_ADDR_BITS])
			return REG_GFX;
		return REG_NONE;
	endfunction

	assign req[MST_CPU] = cpu_cyc && cpu_stb;
	assign req[MST_GFX] = gfx_cyc && gfx_stb;

	assign m_cyc[MST_CPU] = cpu_cyc;
	assign m_cyc[MST_GFX] = gfx_cyc;
	assign m_adr[MST_CPU] = cpu_adr;
	assign m_adr[MST_GFX] = gfx_adr;
	assign m_we[MST_CPU] = cpu_we;
	assign m_we[MST_GFX] = gfx_we;
	assign m_sel[MST_CPU] = cpu_sel;
	assign m_sel[MST_GFX] = gfx_sel;
	assign m_wdata[MST_CPU] = cpu_wdata;
	assign m_wdata[MST_GFX] = gfx_wdata;

	always_comb begin
		if (&req)
			next_grant = ~grant;	// Round robin on a tie
		else
			next_grant = req[MST_GFX] ? MST_GFX : MST_CPU;
	end

	always_ff @(posedge hdmi_pixClk) begin
		if (!sys_rst_n) begin
			state <= ARB_IDLE;
			grant <= MST_CPU;
			region <= REG_NONE;
			err_q <= 1'b0;
		end else begin
			err_q <= 1'b0;
			case (state)
				ARB_IDLE: if (|req) begin
					grant <= next_grant;
					region <= decode(m_adr[next_grant]);
					state <= ARB_ADDR;
				end
				ARB_ADDR: begin
					err_q <= (region == REG_NONE);	// Lands where a slave ack would
					state <= ARB_WAIT;
				end
				ARB_WAIT: if (!m_cyc[grant])
					state <= ARB_IDLE;
				default: state <= ARB_IDLE;
			endcase
		end
	end

	// Shared request toward the slaves
	assign slv_adr = m_adr[grant];
	assign slv_we = m_we[grant];
	assign slv_sel = m_sel[grant];
	assign slv_wdata = m_wdata[grant];

	assign boot_stb = (state == ARB_ADDR) && (region == REG_BOOT);
	assign gfx_slv_stb = (state == ARB_ADDR) && (region == REG_GFX);

	always_comb begin
		resp_ack = 1'b0;
		resp_rdata = '0;
		case (region)
			REG_BOOT: begin
				resp_ack = boot_ack;
				resp_rdata = boot_rdata;
			end
			REG_GFX: begin
				resp_ack = gfx_slv_ack;
				resp_rdata = gfx_slv_rdata;
			end
			default: ;
		endcase
	end

	assign cpu_ack = resp_ack && (grant == MST_CPU);
	assign cpu_err = err_q && (grant == MST_CPU);
	assign cpu_rdata = (grant == MST_CPU) ? resp_rdata : '0;
	assign gfx_ack = resp_ack && (grant == MST_GFX);
	assign gfx_err = err_q && (grant == MST_GFX);
	assign gfx_rdata = (grant == MST_GFX) ? resp_rdata : '0;

endmodule

`default_nettype wire

//--- hw/boot_ram.sv
`timescale 1ns/1ps
`default_nettype none

module boot_ram
	import soc_bus_pkg::*;
#(
	parameter int BOOT_WORDS = 8192
) (
	input wire hdmi_pixClk,
	input wire sys_rst_n,
	input wire stb,
	input wire we,
	input wire addr_t adr,
	input wire sel_t sel,
	input wire data_t wdata,
	output logic ack,
	output data_t rdata
);

	localparam int IDX_W = $clog2(BOOT_WORDS);

	data_t mem [BOOT_WORDS];
	logic [IDX_W-1:0] idx;
	logic access;

	assign idx = adr[IDX_W+1:2];	// Drop byte offset
	assign access = stb && !ack;

	always_ff @(posedge hdmi_pixClk) begin
		if (access && we) begin
			for (int i = 0; i < $bits(sel_t); i++) begin
				if (sel[i])
					mem[idx][8*i +: 8] <= wdata[8*i +: 8];
			end
		end
		if (access)
			rdata <= mem[idx];
	end

	// Single cycle ack pulse
	always_ff @(posedge hdmi_pixClk) begin
		if (!sys_rst_n)
			ack <= 1'b0;
		else
			ack <= access;
	end

endmodule

`default_nettype wire

//--- hw/gfx_regs.sv
`timescale 1ns/1ps
`default_nettype none

module gfx_regs
	import soc_bus_pkg::*;
	import soc_map_pkg::*;
(
	input wire hdmi_pixClk,
	input wire sys_rst_n,
	input wire stb,
	input wire we,
	input wire addr_t adr,
	input wire sel_t sel,
	input wire data_t wdata,
	output logic ack,
	output data_t rdata,
	output logic display_en,
	output addr_t fb_base
);

	gfx_ofs_t ofs;
	logic access;
	data_t ctrl;
	data_t fb_base_q;
	data_t cursor;

	function automatic data_t merge(input data_t old, input data_t nw, input sel_t s);
		data_t res;
		res = old;
		for (int i = 0; i < $bits(sel_t); i++) begin
			if (s[i])
				res[8*i +: 8] = nw[8*i +: 8];
		end
		return res;
	endfunction

	assign ofs = adr[GFX_ADDR_BITS-1:2];
	assign access = stb && !ack;

	always_ff @(posedge hdmi_pixClk) begin
		if (!sys_rst_n) begin
			ack <= 1'b0;
			ctrl <= '0;
			fb_base_q <= '0;
			cursor <= '0;
		end else begin
			ack <= access;
			if (access && we) begin
				case (ofs)
					GFX_CTRL: ctrl <= merge(ctrl, wdata, sel);
					GFX_FB_BASE: fb_base_q <= merge(fb_base_q, wdata, sel);
					GFX_CURSOR: cursor <= merge(cursor, wdata, sel);
					default: ;	// ID and holes ignore writes
				endcase
			end
		end
	end

	always_ff @(posedge hdmi_pixClk) begin
		if (access) begin
			case (ofs)
				GFX_CTRL: rdata <= ctrl;
				GFX_FB_BASE: rdata <= fb_base_q;
				GFX_CURSOR: rdata <= cursor;
				GFX_ID: rdata <= GFX_ID_VALUE;
				default: rdata <= '0;
			endcase
		end
	end

	assign display_en = ctrl[0];
	assign fb_base = fb_base_q;

endmodule

`default_nettype wire

//--- hw/soc_top.sv
`timescale 1ns/1ps
`default_nettype none

module soc_top
	import soc_bus_pkg::*;
#(
	parameter int BOOT_WORDS = 8192,
	parameter int RESET_CYCLES = 255
) (
	input wire hdmi_pixClk,
	input wire rst_n,

	// CPU master port
	input wire cpu_cyc,
	input wire cpu_stb,
	input wire cpu_we,
	input wire addr_t cpu_adr,
	input wire sel_t cpu_sel,
	input wire data_t cpu_wdata,
	output logic cpu_ack,
	output logic cpu_err,
	output data_t cpu_rdata,

	// Graphics engine master port
	input wire gfx_cyc,
	input wire gfx_stb,
	input wire gfx_we,
	input wire addr_t gfx_adr,
	input wire sel_t gfx_sel,
	input wire data_t gfx_wdata,
	output logic gfx_ack,
	output logic gfx_err,
	output data_t gfx_rdata,

	output logic core_rst_n,
	output logic display_en,
	output addr_t fb_base
);

	logic sys_rst_n;
	addr_t slv_adr;
	logic slv_we;
	sel_t slv_sel;
	data_t slv_wdata;
	logic boot_stb;
	logic boot_ack;
	data_t boot_rdata;
	logic gfx_slv_stb;
	logic gfx_slv_ack;
	data_t gfx_slv_rdata;

	assign core_rst_n = sys_rst_n;

	reset_seq #(
		.RESET_CYCLES(RESET_CYCLES)
	) i_reset_seq (
		.hdmi_pixClk(hdmi_pixClk),
		.rst_n(rst_n),
		.sys_rst_n(sys_rst_n)
	);

	bus_ctrl i_bus_ctrl (
		.hdmi_pixClk(hdmi_pixClk),
		.sys_rst_n(sys_rst_n),
		.cpu_cyc(cpu_cyc),
		.cpu_stb(cpu_stb),
		.cpu_we(cpu_we),
		.cpu_adr(cpu_adr),
		.cpu_sel(cpu_sel),
		.cpu_wdata(cpu_wdata),
		.cpu_ack(cpu_ack),
		.cpu_err(cpu_err),
		.cpu_rdata(cpu_rdata),
		.gfx_cyc(gfx_cyc),
		.gfx_stb(gfx_stb),
		.gfx_we(gfx_we),
		.gfx_adr(gfx_adr),
		.gfx_sel(gfx_sel),
		.gfx_wdata(gfx_wdata),
		.gfx_ack(gfx_ack),
		.gfx_err(gfx_err),
		.gfx_rdata(gfx_rdata),
		.slv_adr(slv_adr),
		.slv_we(slv_we),
		.slv_sel(slv_sel),
		.slv_wdata(slv_wdata),
		.boot_stb(boot_stb),
		.boot_ack(boot_ack),
		.boot_rdata(boot_rdata),
		.gfx_slv_stb(gfx_slv_stb),
		.gfx_slv_ack(gfx_slv_ack),
		.gfx_slv_rdata(gfx_slv_rdata)
	);

	boot_ram #(
		.BOOT_WORDS(BOOT_WORDS)
	) i_boot_ram (
		.hdmi_pixClk(hdmi_pixClk),
		.sys_rst_n(sys_rst_n),
		.stb(boot_stb),
		.we(slv_we),
		.adr(slv_adr),
		.sel(slv_sel),
		.wdata(slv_wdata),
		.ack(boot_ack),
		.rdata(boot_rdata)
	);

	gfx_regs i_gfx_regs (
		.hdmi_pixClk(hdmi_pixClk),
		.sys_rst_n(sys_rst_n),
		.stb(gfx_slv_stb),
		.we(slv_we),
		.adr(slv_adr),
		.sel(slv_sel),
		.wdata(slv_wdata),
		.ack(gfx_slv_ack),
		.rdata(gfx_slv_rdata),
		.display_en(display_en),
		.fb_base(fb_base)
	);

endmodule

`default_nettype wire

//--- testbench/soc_top_chk.sv
`timescale 1ns/1ps
`default_nettype none

module soc_top_chk
	import soc_bus_pkg::*;
	import soc_map_pkg::*;
(
	input wire hdmi_pixClk,
	input wire sys_rst_n,
	input wire cpu_cyc,
	input wire cpu_stb,
	input wire cpu_ack,
	input wire cpu_err,
	input wire gfx_cyc,
	input wire gfx_stb,
	input wire gfx_ack,
	input wire gfx_err,
	input wire addr_t slv_adr,
	input wire boot_stb,
	input wire gfx_slv_stb,
	input wire master_t grant
);

	logic grant_cyc;
	logic boot_hit;
	logic gfx_hit;

	assign grant_cyc = (grant == MST_GFX) ? gfx_cyc : cpu_cyc;

	// Address inside base plus window size
	assign boot_hit = (slv_adr - BOOT_BASE) < (addr_t'(1) << BOOT_ADDR_BITS);
	assign gfx_hit = (slv_adr - GFX_BASE) < (addr_t'(1) << GFX_ADDR_BITS);

	a_resp_excl: assert property (@(posedge hdmi_pixClk) disable iff (!sys_rst_n)
		!(cpu_ack && cpu_err) && !(gfx_ack && gfx_err))
		else $error("ack and err high together");

	// Response only to a master that is strobing
	a_resp_to_stb: assert property (@(posedge hdmi_pixClk) disable iff (!sys_rst_n)
		(!(cpu_ack || cpu_err) || cpu_stb) && (!(gfx_ack || gfx_err) || gfx_stb))
		else $error("response sent to a master without stb");

	a_one_slave: assert property (@(posedge hdmi_pixClk) disable iff (!sys_rst_n)
		!(boot_stb && gfx_slv_stb) && (!boot_stb || boot_hit)
		&& (!gfx_slv_stb || gfx_hit))
		else $error("slave strobe outside its window or two strobes together");

	a_grant_held: assert property (@(posedge hdmi_pixClk) disable iff (!sys_rst_n)
		(grant_cyc && $past(grant_cyc)) |=> $stable(grant))
		else $error("grant moved during an open cycle");

endmodule

bind bus_ctrl soc_top_chk i_soc_top_chk (
	.hdmi_pixClk(hdmi_pixClk),
	.sys_rst_n(sys_rst_n),
	.cpu_cyc(cpu_cyc),
	.cpu_stb(cpu_stb),
	.cpu_ack(cpu_ack),
	.cpu_err(cpu_err),
	.gfx_cyc(gfx_cyc),
	.gfx_stb(gfx_stb),
	.gfx_ack(gfx_ack),
	.gfx_err(gfx_err),
	.slv_adr(slv_adr),
	.boot_stb(boot_stb),
	.gfx_slv_stb(gfx_slv_stb),
	.grant(grant)
);

`default_nettype wire

//--- testbench/tb_soc_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_soc_top
	import soc_bus_pkg::*;
	import soc_map_pkg::*;
#(
	parameter int BOOT_WORDS = 8192,
	parameter int RESET_CYCLES = 255
);

	localparam string INPUT_FILE = "testbench/bus_input.txt";
	localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;
	localparam int K_OK = 0;
	localparam int K_ERR = 1;
	localparam int K_DATA = 2;

	logic hdmi_pixClk;
	logic rst_n;
	logic cpu_cyc, cpu_stb, cpu_we;
	addr_t cpu_adr;
	sel_t cpu_sel;
	data_t cpu_wdata;
	logic cpu_ack, cpu_err;
	data_t cpu_rdata;
	logic gfx_cyc, gfx_stb, gfx_we;
	addr_t gfx_adr;
	sel_t gfx_sel;
	data_t gfx_wdata;
	logic gfx_ack, gfx_err;
	data_t gfx_rdata;
	logic core_rst_n;
	logic display_en;
	addr_t fb_base;

	// One entry per transaction line
	byte tag_q[$];
	master_t mst_q[$];
	logic we_q[$];
	addr_t adr_q[$];
	sel_t sel_q[$];
	data_t wdata_q[$];
	int kind_q[$];
	data_t exp_q[$];

	int cycle_cnt;
	int timeout_limit;
	int err_cnt;
	logic [31:0] lfsr;
	master_t last_served;
	data_t exp_ctrl;	// Pin model
	data_t exp_fb;

	soc_top #(
		.BOOT_WORDS(BOOT_WORDS),
		.RESET_CYCLES(RESET_CYCLES)
	) i_soc_top (.*);

	initial begin
		hdmi_pixClk = 1'b0;
		forever #5 hdmi_pixClk = ~hdmi_pixClk;
	end

	always @(posedge hdmi_pixClk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= timeout_limit) begin
			$display("Timeout: the run did not finish within %0d cycles", timeout_limit);
			$display("Errors found");
			$fatal(1, "stopped by the watchdog");
		end
	end

	task automatic stop_run();
		err_cnt++;
		$display("Errors found");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic fail_plain(input string why);
		$display("%s", why);
		stop_run();
	endtask

	task automatic check_data(input string name, input data_t got, input data_t exp);
		if (got !== exp) begin
			$display("MISMATCH at %0t: %s is %h, expected %h", $time, name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_addr(input string name, input addr_t got, input addr_t exp);
		if (got !== exp) begin
			$display("MISMATCH at %0t: %s is %h, expected %h", $time, name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("MISMATCH at %0t: %s is %b, expected %b", $time, name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp) begin
			$display("MISMATCH at %0t: %s is %0d, expected %0d", $time, name, got, exp);
			stop_run();
		end
	endtask

	// Two bits per gap, one LFSR step each
	function automatic int idle_cycles();
		int n;
		n = 0;
		for (int b = 0; b < 2; b++) begin
			n = (n << 1) | int'(lfsr[0]);
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);
		end
		return n;
	endfunction

	task automatic step_cycle();
		@(posedge hdmi_pixClk);
		#1;
	endtask

	task automatic drive_req(input master_t m, input logic act, input logic we,
			input addr_t adr, input sel_t sel, input data_t wdata);
		if (m == MST_CPU) begin
			cpu_cyc = act;
			cpu_stb = act;
			cpu_we = we;
			cpu_adr = adr;
			cpu_sel = sel;
			cpu_wdata = wdata;
		end else begin
			gfx_cyc = act;
			gfx_stb = act;
			gfx_we = we;
			gfx_adr = adr;
			gfx_sel = sel;
			gfx_wdata = wdata;
		end
	endtask

	// Graphics CTRL and FB_BASE as seen at the pins
	task automatic update_pin_model(input addr_t adr, input sel_t sel, input data_t wdata);
		data_t word;
		if ((adr >> GFX_ADDR_BITS) != (GFX_BASE >> GFX_ADDR_BITS))
			return;
		word = (adr[GFX_ADDR_BITS-1:2] == GFX_CTRL) ? exp_ctrl : exp_fb;
		for (int i = 0; i < 4; i++) begin
			if (sel[i])
				word[8*i +: 8] = wdata[8*i +: 8];
		end
		if (adr[GFX_ADDR_BITS-1:2] == GFX_CTRL)
			exp_ctrl = word;
		else if (adr[GFX_ADDR_BITS-1:2] == GFX_FB_BASE)
			exp_fb = word;
	endtask

	task automatic run_xfer(input int i, output int done_at);
		logic ack;
		logic err;
		data_t rdata;
		string pfx;
		pfx = (mst_q[i] == MST_CPU) ? "cpu" : "gfx";
		drive_req(mst_q[i], 1'b1, we_q[i], adr_q[i], sel_q[i], wdata_q[i]);
		do begin
			step_cycle();
			ack = (mst_q[i] == MST_CPU) ? cpu_ack : gfx_ack;
			err = (mst_q[i] == MST_CPU) ? cpu_err : gfx_err;
			rdata = (mst_q[i] == MST_CPU) ? cpu_rdata : gfx_rdata;
		end while (!ack && !err);
		done_at = cycle_cnt;
		last_served = mst_q[i];
		check_bit({pfx, "_ack"}, ack, kind_q[i] != K_ERR);
		check_bit({pfx, "_err"}, err, kind_q[i] == K_ERR);
		if (kind_q[i] == K_DATA)
			check_data({pfx, "_rdata"}, rdata, exp_q[i]);
		if (kind_q[i] == K_OK && we_q[i])
			update_pin_model(adr_q[i], sel_q[i], wdata_q[i]);
		step_cycle();	// Hold stb through the ack edge
		drive_req(mst_q[i], 1'b0, 1'b0, '0, '0, '0);
		step_cycle();
	endtask

	task automatic load_input();
		int fd;
		int n;
		string line;
		string tag, mst, op, res;
		addr_t adr;
		sel_t sel;
		data_t wdata;
		data_t rd;
		fd = $fopen(INPUT_FILE, "r");
		if (fd == 0)
			fail_plain({"Cannot open the stimulus file ", INPUT_FILE});
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() < 2 || line[0] == "#")
				continue;
			n = $sscanf(line, "%s %s %s %h %h %h %s", tag, mst, op, adr, sel, wdata, res);
			if (n != 7)
				fail_plain({"Malformed stimulus line: ", line});
			tag_q.push_back(tag[0]);
			mst_q.push_back((mst == "G") ? MST_GFX : MST_CPU);
			we_q.push_back(op == "W");
			adr_q.push_back(adr);
			sel_q.push_back(sel);
			wdata_q.push_back(wdata);
			rd = '0;
			if (res == "OK") begin
				kind_q.push_back(K_OK);
			end else if (res == "ERR") begin
				kind_q.push_back(K_ERR);
			end else begin
				void'($sscanf(res, "%h", rd));
				kind_q.push_back(K_DATA);
			end
			exp_q.push_back(rd);
		end
		$fclose(fd);
	endtask

	initial begin
		int i;
		int n;
		int done_a;
		int done_b;
		int pairs;
		master_t first;
		master_t prev_first;
		master_t exp_first;
		rst_n = 1'b0;
		drive_req(MST_CPU, 1'b0, 1'b0, '0, '0, '0);
		drive_req(MST_GFX, 1'b0, 1'b0, '0, '0, '0);
		cycle_cnt = 0;
		err_cnt = 0;
		lfsr = 32'h339b3c4d;
		exp_ctrl = '0;
		exp_fb = '0;
		pairs = 0;
		prev_first = MST_CPU;
		last_served = MST_CPU;	// Grant resets to the CPU
		load_input();
		timeout_limit = tag_q.size() * 8 + RESET_CYCLES + 100;

		repeat (16) @(posedge hdmi_pixClk);
		#1;
		rst_n = 1'b1;
		// Both masters already request while reset is stretched
		drive_req(MST_CPU, 1'b1, 1'b0, BOOT_BASE, '1, '0);
		drive_req(MST_GFX, 1'b1, 1'b0, GFX_BASE, '1, '0);
		step_cycle();	// First edge with rst_n high
		n = 0;
		while (!core_rst_n) begin
			check_bit("cpu_ack", cpu_ack, 1'b0);
			check_bit("gfx_ack", gfx_ack, 1'b0);
			step_cycle();
			n++;
		end
		drive_req(MST_CPU, 1'b0, 1'b0, '0, '0, '0);
		drive_req(MST_GFX, 1'b0, 1'b0, '0, '0, '0);
		check_count("core_rst_n delay", n, RESET_CYCLES + 1);
		check_bit("display_en", display_en, 1'b0);
		check_addr("fb_base", fb_base, '0);
		step_cycle();

		i = 0;
		while (i < tag_q.size()) begin
			repeat (idle_cycles())
				step_cycle();
			if (tag_q[i] == "P") begin
				if (i + 1 >= tag_q.size() || tag_q[i+1] != "P" || mst_q[i] == mst_q[i+1])
					fail_plain($sformatf("Line %0d starts a pair without a partner", i));
				exp_first = ~last_served;	// Round robin on a tie
				fork
					run_xfer(i, done_a);
					run_xfer(i + 1, done_b);
				join
				if (done_a == done_b)
					fail_plain("Both masters were answered in the same cycle");
				first = (done_a < done_b) ? mst_q[i] : mst_q[i+1];
				check_bit("first_ack_master", first, exp_first);
				if (pairs > 0)
					check_bit("first_ack_alternates", first != prev_first, 1'b1);
				prev_first = first;
				pairs++;
				i += 2;
			end else begin
				run_xfer(i, done_a);
				i++;
			end
			check_bit("display_en", display_en, exp_ctrl[0]);
			check_addr("fb_base", fb_base, exp_fb);
		end

		if (err_cnt == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

`default_nettype wire

//--- compile.f
hw/soc_bus_pkg.sv
hw/soc_map_pkg.sv
hw/reset_seq.sv
hw/bus_ctrl.sv
hw/boot_ram.sv
hw/gfx_regs.sv
hw/soc_top.sv
testbench/soc_top_chk.sv
testbench/tb_soc_top.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_soc_top -f compile.f --Mdir obj_dir

output=$(./obj_dir/Vtb_soc_top) || true
echo "$output"

if grep -qx "No errors" <<< "$output"; then
	exit 0
fi
exit 1

//--- testbench/bus_input.txt
# tag (S single, P pair) master (C cpu, G gfx) op (W, R) address sel wdata expected
# expected is OK, ERR or the read data in hex
S C W 02010000 f 11223344 OK
S C R 02010000 f 00000000 11223344
S G W 02010004 f a5a5a5a5 OK
S C W 02010004 2 0000bb00 OK
S G W 02010004 8 cc000000 OK
S C R 02010004 f 00000000 cca5bba5
S G W 02017ffc f deadbeef OK
S G R 02017ffc f 00000000 deadbeef
S C R 02000000 f 00000000 00000000
S C W 02000004 f 00100000 OK
S C W 02000000 1 00000001 OK
S G R 02000004 f 00000000 00100000
S C W 02000008 3 00001234 OK
S C R 02000008 f 00000000 00001234
S C W 0200000c f ffffffff OK
S G R 0200000c f 00000000 47580001
# SDRAM window and holes next to the boot and graphics windows
S C W 80000000 f 12345678 ERR
S G R 80000010 f 00000000 ERR
S C W 02018000 f 99999999 ERR
S G W 02000100 f 00000000 ERR
S C R 02010000 f 00000000 11223344
S G R 02000000 f 00000000 00000001
# Between pairs a single from the last pair winner
P C R 02010004 f 00000000 cca5bba5
P G W 02000004 f 00200000 OK
S C R 02000004 f 00000000 00200000
P C W 02010008 f 0badf00d OK
P G R 02010000 f 00000000 11223344
S G R 02010008 f 00000000 0badf00d
P G R 0200000c f 00000000 47580001
P C W 02000000 f 00000000 OK
S C R 02000000 f 00000000 00000000
